// ==== rtl/if_pkg.sv ====
// shared types of the instruction fetch stage
// address and instruction words, mux selects, trap CSR bundle
// fetch response, IF-ID word and the fetch FSM states
`default_nettype none

package if_pkg;

  ////////////////////////////////////////////////////////////
  // plain vector types
  ////////////////////////////////////////////////////////////

  // byte address, used for PCs and bus addresses
  typedef logic [31:0] addr_t;

  // one uncompressed instruction word
  typedef logic [31:0] instr_t;

  // interrupt cause index for vectored mode
  typedef logic [4:0] irq_vec_t;

  // low byte of the boot address, the upper 24 bits come from boot_addr_i
  localparam logic [7:0] BootOffset = 8'h80;

  ////////////////////////////////////////////////////////////
  // mux selects
  ////////////////////////////////////////////////////////////

  // source of the next fetch address
  typedef enum logic [2:0] {
    PC_BOOT = 3'd0,
    PC_JUMP = 3'd1,
    PC_EXC  = 3'd2,
    PC_ERET = 3'd3,
    PC_DRET = 3'd4
  } pc_sel_e;

  // trap target mode
  typedef enum logic [2:0] {
    EXC_PC_EXC      = 3'd0,
    EXC_PC_IRQ      = 3'd1,
    EXC_PC_DBD      = 3'd2,
    EXC_PC_DBG_EXC  = 3'd3,
    EXC_PC_IRQ_CLIC = 3'd4
  } exc_pc_sel_e;

  ////////////////////////////////////////////////////////////
  // bundles
  ////////////////////////////////////////////////////////////

  // trap related CSRs as seen by the fetch stage
  typedef struct packed {
    addr_t mtvec;
    addr_t mepc;
    addr_t depc;
    // CLIC vector table base
    addr_t mtvt;
  } trap_csr_t;

  // one word returned by the fetch unit
  typedef struct packed {
    addr_t  addr;
    instr_t instr;
    logic   err;
  } fetch_rsp_t;

  // contents of the IF-ID register
  typedef struct packed {
    instr_t instr;
    addr_t  pc;
    logic   fetch_err;
  } id_instr_t;

  // fetch unit FSM
  typedef enum logic [1:0] {
    FETCH_IDLE = 2'd0,
    FETCH_REQ  = 2'd1,
    FETCH_WAIT = 2'd2,
    FETCH_HOLD = 2'd3
  } fetch_state_e;

endpackage

`default_nettype wire

// ==== rtl/exc_pc_gen.sv ====
// trap target address generation
// basic, vectored, debug and CLIC modes with the SHV table entry
`default_nettype none

module exc_pc_gen import if_pkg::*; #(
  parameter addr_t       DmHaltAddr      = 32'h1A11_0800,
  parameter addr_t       DmExceptionAddr = 32'h1A11_0808,
  parameter int unsigned NumInterrupts   = 64,
  parameter bit          ClicShv         = 1'b1
) (
  input  trap_csr_t                        csr_i,
  input  exc_pc_sel_e                      exc_pc_mux_i,
  input  irq_vec_t                         exc_cause_i,
  input  logic                             irq_shv_i,
  input  logic [$clog2(NumInterrupts)-1:0] clic_irq_id_i,
  output addr_t                            exc_pc_o
);

  addr_t clic_base;
  addr_t clic_entry;
  addr_t clic_offset;

  // mtvt is 64 byte aligned, one word per interrupt id
  assign clic_base   = {csr_i.mtvt[31:6], 6'b00_0000};
  assign clic_offset = addr_t'(clic_irq_id_i) << 2;
  assign clic_entry  = clic_base + clic_offset;

  always_comb begin
    unique case (exc_pc_mux_i)
      // basic mode, single handler
      EXC_PC_EXC:      exc_pc_o = {csr_i.mtvec[31:8], 8'h00};
      // vectored mode, cause selects the word in the table
      EXC_PC_IRQ:      exc_pc_o = {csr_i.mtvec[31:8], 1'b0, exc_cause_i, 2'b00};
      EXC_PC_DBD:      exc_pc_o = DmHaltAddr;
      EXC_PC_DBG_EXC:  exc_pc_o = DmExceptionAddr;
      // selective hardware vectoring jumps to the table entry itself
      EXC_PC_IRQ_CLIC: begin
        if (ClicShv && irq_shv_i) begin
          exc_pc_o = clic_entry;
        end else begin
          exc_pc_o = {csr_i.mtvec[31:6], 6'b00_0000};
        end
      end
      default:         exc_pc_o = {csr_i.mtvec[31:8], 8'h00};
    endcase
  end

endmodule

`default_nettype wire

// ==== rtl/pc_sel.sv ====
// next fetch address selection
// minhv flag and CSR init strobes at boot
`default_nettype none

module pc_sel import if_pkg::*; #(
  parameter addr_t       DmHaltAddr      = 32'h1A11_0800,
  parameter addr_t       DmExceptionAddr = 32'h1A11_0808,
  parameter int unsigned NumInterrupts   = 64,
  parameter bit          ClicShv         = 1'b1
) (
  input  addr_t                            boot_addr_i,
  input  trap_csr_t                        csr_i,
  input  logic                             pc_set_i,
  input  pc_sel_e                          pc_mux_i,
  input  exc_pc_sel_e                      exc_pc_mux_i,
  input  irq_vec_t                         exc_cause_i,
  input  logic                             irq_shv_i,
  input  logic [$clog2(NumInterrupts)-1:0] clic_irq_id_i,
  input  addr_t                            branch_target_i,
  output addr_t                            fetch_addr_o,
  output logic                             minhv_o,
  output logic                             csr_mtvec_init_o,
  output logic                             csr_mtvt_init_o
);

  addr_t exc_pc;
  addr_t boot_pc;
  logic  boot_set;

  exc_pc_gen #(
    .DmHaltAddr      (DmHaltAddr),
    .DmExceptionAddr (DmExceptionAddr),
    .NumInterrupts   (NumInterrupts),
    .ClicShv         (ClicShv)
  ) i_exc_pc_gen (
    .csr_i         (csr_i),
    .exc_pc_mux_i  (exc_pc_mux_i),
    .exc_cause_i   (exc_cause_i),
    .irq_shv_i     (irq_shv_i),
    .clic_irq_id_i (clic_irq_id_i),
    .exc_pc_o      (exc_pc)
  );

  // boot address keeps only its upper 24 bits
  assign boot_pc = {boot_addr_i[31:8], BootOffset};

  always_comb begin
    unique case (pc_mux_i)
      PC_BOOT: fetch_addr_o = boot_pc;
      PC_JUMP: fetch_addr_o = branch_target_i;
      PC_EXC:  fetch_addr_o = exc_pc;
      // return from trap
      PC_ERET: fetch_addr_o = csr_i.mepc;
      // return from debug mode
      PC_DRET: fetch_addr_o = csr_i.depc;
      default: fetch_addr_o = boot_pc;
    endcase
  end

  // handler entered through the SHV table, only meaningful on a PC set
  assign minhv_o = pc_set_i & (pc_mux_i == PC_EXC) & ClicShv & irq_shv_i;

  // CSR file loads mtvec and mtvt from the boot address
  assign boot_set         = pc_set_i & (pc_mux_i == PC_BOOT);
  assign csr_mtvec_init_o = boot_set;
  assign csr_mtvt_init_o  = boot_set;

endmodule

`default_nettype wire

// ==== rtl/fetch_unit.sv ====
// instruction bus master with one request in flight
// sequential word fetch, redirect on branch, one word held on stall
`default_nettype none

module fetch_unit import if_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       req_i,
  input  logic       branch_i,
  input  addr_t      branch_addr_i,
  input  logic       ready_i,
  output logic       valid_o,
  output fetch_rsp_t rsp_o,
  output logic       busy_o,
  output logic       instr_req_o,
  output addr_t      instr_addr_o,
  input  logic       instr_gnt_i,
  input  logic       instr_rvalid_i,
  input  instr_t     instr_rdata_i,
  input  logic       instr_err_i
);

  fetch_state_e state_q, state_d;
  // address on the bus, or of the word in flight or held
  addr_t        addr_q, addr_d;
  // redirect target, waiting for a cancelled response
  addr_t        tgt_q, tgt_d;
  addr_t        branch_word;
  addr_t        addr_incr;
  logic         addr_valid_q, addr_valid_d;
  logic         discard_q, discard_d;
  logic         hold_en;
  fetch_rsp_t   bus_rsp;
  fetch_rsp_t   hold_q;

  // only whole words are fetched
  assign branch_word = {branch_addr_i[31:2], 2'b00};
  assign addr_incr   = addr_q + 32'd4;
  assign bus_rsp     = '{addr: addr_q, instr: instr_rdata_i, err: instr_err_i};

  ////////////////////////////////////////////////////////////
  // fetch FSM
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_d      = state_q;
    addr_d       = addr_q;
    tgt_d        = tgt_q;
    discard_d    = discard_q;
    addr_valid_d = addr_valid_q | branch_i;
    hold_en      = 1'b0;

    unique case (state_q)
      FETCH_IDLE: begin
        if (branch_i) begin
          addr_d  = branch_word;
          state_d = FETCH_REQ;
        end else if (req_i && addr_valid_q) begin
          // resume at the address after the last accepted word
          state_d = FETCH_REQ;
        end
      end
      FETCH_REQ: begin
        // request stays on the bus until granted, its data is dropped later
        if (branch_i) begin
          discard_d = 1'b1;
          tgt_d     = branch_word;
        end
        if (instr_gnt_i) begin
          state_d = FETCH_WAIT;
        end
      end
      FETCH_WAIT: begin
        if (instr_rvalid_i) begin
          if (branch_i || discard_q) begin
            // cancelled word, go to the newest target
            addr_d    = branch_i ? branch_word : tgt_q;
            discard_d = 1'b0;
            state_d   = FETCH_REQ;
          end else if (ready_i) begin
            addr_d  = addr_incr;
            state_d = req_i ? FETCH_REQ : FETCH_IDLE;
          end else begin
            hold_en = 1'b1;
            state_d = FETCH_HOLD;
          end
        end else if (branch_i) begin
          discard_d = 1'b1;
          tgt_d     = branch_word;
        end
      end
      FETCH_HOLD: begin
        if (branch_i) begin
          addr_d  = branch_word;
          state_d = FETCH_REQ;
        end else if (ready_i) begin
          addr_d  = addr_incr;
          state_d = req_i ? FETCH_REQ : FETCH_IDLE;
        end
      end
      default: state_d = FETCH_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= FETCH_IDLE;
      addr_valid_q <= 1'b0;
      discard_q    <= 1'b0;
    end else begin
      state_q      <= state_d;
      addr_valid_q <= addr_valid_d;
      discard_q    <= discard_d;
    end
  end

  always_ff @(posedge clk_i) begin
    addr_q <= addr_d;
    tgt_q  <= tgt_d;
    if (hold_en) begin
      hold_q <= bus_rsp;
    end
  end

  ////////////////////////////////////////////////////////////
  // outputs
  ////////////////////////////////////////////////////////////

  // word straight from the bus or from the hold register, never in a branch cycle
  assign valid_o = ~branch_i &
                   ((state_q == FETCH_HOLD) |
                    ((state_q == FETCH_WAIT) & instr_rvalid_i & ~discard_q));
  assign rsp_o   = (state_q == FETCH_HOLD) ? hold_q : bus_rsp;

  assign instr_req_o  = (state_q == FETCH_REQ);
  assign instr_addr_o = addr_q;
  assign busy_o       = (state_q != FETCH_IDLE);

endmodule

`default_nettype wire

// ==== rtl/if_id_regs.sv ====
// IF-ID pipeline register
// valid and new flags, bus and PMP errors merged into one fetch error
`default_nettype none

module if_id_regs import if_pkg::*; #(
  parameter bit ResetAll = 1'b0
) (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       fetch_valid_i,
  input  fetch_rsp_t fetch_rsp_i,
  input  logic       pmp_err_i,
  input  logic       id_in_ready_i,
  input  logic       pc_set_i,
  input  logic       instr_valid_clear_i,
  output logic       fetch_ready_o,
  output logic       accept_o,
  output id_instr_t  id_instr_o,
  output logic       instr_valid_id_o,
  output logic       instr_new_id_o
);

  logic      valid_d, valid_q;
  logic      new_q;
  id_instr_t id_instr_d;

  // ID takes a word whenever it is ready
  assign fetch_ready_o = id_in_ready_i;
  assign accept_o      = fetch_valid_i & id_in_ready_i;

  // a word taken together with a PC set is squashed
  assign valid_d = (accept_o & ~pc_set_i) | (valid_q & ~instr_valid_clear_i);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
      new_q   <= 1'b0;
    end else begin
      valid_q <= valid_d;
      new_q   <= accept_o;
    end
  end

  assign id_instr_d = '{instr:     fetch_rsp_i.instr,
                        pc:        fetch_rsp_i.addr,
                        fetch_err: fetch_rsp_i.err | pmp_err_i};

  // data register, written on accept only
  if (ResetAll) begin : g_data_ra
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        id_instr_o <= '0;
      end else if (accept_o) begin
        id_instr_o <= id_instr_d;
      end
    end
  end else begin : g_data_nr
    always_ff @(posedge clk_i) begin
      if (accept_o) begin
        id_instr_o <= id_instr_d;
      end
    end
  end

  assign instr_valid_id_o = valid_q;
  assign instr_new_id_o   = new_q;

endmodule

`default_nettype wire

// ==== rtl/pc_incr_check.sv ====
// sequential PC check
// alert when the next word does not follow the one in ID
`default_nettype none

module pc_incr_check import if_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_ni,
  input  logic  accept_i,
  input  logic  branch_i,
  input  logic  fetch_err_i,
  input  addr_t pc_if_i,
  input  addr_t pc_id_i,
  output logic  alert_o
);

  logic  seq_d, seq_q;
  addr_t pc_expected;

  // sequence starts with an accepted word
  // any redirect or erroneous fetch breaks it
  assign seq_d = (seq_q | accept_i) & ~branch_i & ~fetch_err_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      seq_q <= 1'b0;
    end else begin
      seq_q <= seq_d;
    end
  end

  assign pc_expected = pc_id_i + 32'd4;

  // checked when the following word is taken into ID
  assign alert_o = seq_q & accept_i & (pc_if_i != pc_expected);

endmodule

`default_nettype wire

// ==== rtl/if_stage_top.sv ====
// instruction fetch stage top level
// PC selection, fetch unit, IF-ID register and PC check
`default_nettype none

module if_stage_top import if_pkg::*; #(
  parameter addr_t       DmHaltAddr      = 32'h1A11_0800,
  parameter addr_t       DmExceptionAddr = 32'h1A11_0808,
  parameter int unsigned NumInterrupts   = 64,
  parameter bit          ClicShv         = 1'b1,
  parameter bit          ResetAll        = 1'b0,
  parameter bit          PcIncrCheck     = 1'b1
) (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  addr_t                            boot_addr_i,
  input  logic                             req_i,
  // instruction bus
  output logic                             instr_req_o,
  output addr_t                            instr_addr_o,
  input  logic                             instr_gnt_i,
  input  logic                             instr_rvalid_i,
  input  instr_t                           instr_rdata_i,
  input  logic                             instr_err_i,
  // control from the core
  input  logic                             pc_set_i,
  input  pc_sel_e                          pc_mux_i,
  input  exc_pc_sel_e                      exc_pc_mux_i,
  input  irq_vec_t                         exc_cause_i,
  input  logic                             irq_shv_i,
  input  logic [$clog2(NumInterrupts)-1:0] clic_irq_id_i,
  input  addr_t                            branch_target_i,
  input  trap_csr_t                        csr_i,
  input  logic                             pmp_err_i,
  input  logic                             id_in_ready_i,
  input  logic                             instr_valid_clear_i,
  // towards ID and the CSR file
  output id_instr_t                        id_instr_o,
  output logic                             instr_valid_id_o,
  output logic                             instr_new_id_o,
  output addr_t                            pc_if_o,
  output logic                             minhv_o,
  output logic                             csr_mtvec_init_o,
  output logic                             csr_mtvt_init_o,
  output logic                             pc_mismatch_alert_o,
  output logic                             if_busy_o
);

  addr_t      fetch_addr_n;
  logic       fetch_valid;
  logic       fetch_ready;
  fetch_rsp_t fetch_rsp;
  logic       instr_new_id_d;

  pc_sel #(
    .DmHaltAddr      (DmHaltAddr),
    .DmExceptionAddr (DmExceptionAddr),
    .NumInterrupts   (NumInterrupts),
    .ClicShv         (ClicShv)
  ) i_pc_sel (
    .boot_addr_i      (boot_addr_i),
    .csr_i            (csr_i),
    .pc_set_i         (pc_set_i),
    .pc_mux_i         (pc_mux_i),
    .exc_pc_mux_i     (exc_pc_mux_i),
    .exc_cause_i      (exc_cause_i),
    .irq_shv_i        (irq_shv_i),
    .clic_irq_id_i    (clic_irq_id_i),
    .branch_target_i  (branch_target_i),
    .fetch_addr_o     (fetch_addr_n),
    .minhv_o          (minhv_o),
    .csr_mtvec_init_o (csr_mtvec_init_o),
    .csr_mtvt_init_o  (csr_mtvt_init_o)
  );

  // every PC set redirects the fetch unit
  fetch_unit i_fetch_unit (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .req_i          (req_i),
    .branch_i       (pc_set_i),
    .branch_addr_i  (fetch_addr_n),
    .ready_i        (fetch_ready),
    .valid_o        (fetch_valid),
    .rsp_o          (fetch_rsp),
    .busy_o         (if_busy_o),
    .instr_req_o    (instr_req_o),
    .instr_addr_o   (instr_addr_o),
    .instr_gnt_i    (instr_gnt_i),
    .instr_rvalid_i (instr_rvalid_i),
    .instr_rdata_i  (instr_rdata_i),
    .instr_err_i    (instr_err_i)
  );

  if_id_regs #(
    .ResetAll (ResetAll)
  ) i_if_id_regs (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .fetch_valid_i       (fetch_valid),
    .fetch_rsp_i         (fetch_rsp),
    .pmp_err_i           (pmp_err_i),
    .id_in_ready_i       (id_in_ready_i),
    .pc_set_i            (pc_set_i),
    .instr_valid_clear_i (instr_valid_clear_i),
    .fetch_ready_o       (fetch_ready),
    .accept_o            (instr_new_id_d),
    .id_instr_o          (id_instr_o),
    .instr_valid_id_o    (instr_valid_id_o),
    .instr_new_id_o      (instr_new_id_o)
  );

  assign pc_if_o = fetch_rsp.addr;

  if (PcIncrCheck) begin : g_pc_check
    pc_incr_check i_pc_incr_check (
      .clk_i       (clk_i),
      .rst_ni      (rst_ni),
      .accept_i    (instr_new_id_d),
      .branch_i    (pc_set_i),
      .fetch_err_i (fetch_rsp.err | pmp_err_i),
      .pc_if_i     (fetch_rsp.addr),
      .pc_id_i     (id_instr_o.pc),
      .alert_o     (pc_mismatch_alert_o)
    );
  end else begin : g_no_pc_check
    assign pc_mismatch_alert_o = 1'b0;
  end

endmodule

`default_nettype wire

// ==== bench/if_stage_sva.sv ====
// bound assertions on the fetch stage
// bus request rules, minhv qualifier and reset values
`default_nettype none

module if_stage_sva import if_pkg::*; (
  input logic  clk_i,
  input logic  rst_ni,
  input logic  instr_req_o,
  input addr_t instr_addr_o,
  input logic  instr_gnt_i,
  input logic  pc_set_i,
  input logic  minhv_o,
  input logic  instr_valid_id_o,
  input logic  instr_new_id_o,
  input logic  csr_mtvec_init_o,
  input logic  csr_mtvt_init_o,
  input logic  pc_mismatch_alert_o,
  input logic  if_busy_o
);

  int unsigned fail_cnt = 0;
  logic        outs_low;

  assign outs_low = ~(instr_req_o | instr_valid_id_o | instr_new_id_o | minhv_o |
                      csr_mtvec_init_o | csr_mtvt_init_o | pc_mismatch_alert_o | if_busy_o);

  // request strobe is always known
  req_known: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !$isunknown(instr_req_o))
    else begin
      $error("instruction request is unknown");
      fail_cnt++;
    end

  // word aligned, known address
  req_aligned: assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_req_o |-> !$isunknown(instr_addr_o) && (instr_addr_o[1:0] == 2'b00))
    else begin
      $error("instruction request with a misaligned or unknown address");
      fail_cnt++;
    end

  // request held with a stable address until granted
  req_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_req_o && !instr_gnt_i |=> instr_req_o && $stable(instr_addr_o))
    else begin
      $error("instruction request dropped or changed before grant");
      fail_cnt++;
    end

  minhv_qual: assert property (@(posedge clk_i) disable iff (!rst_ni)
    minhv_o |-> pc_set_i)
    else begin
      $error("minhv without a PC set");
      fail_cnt++;
    end

  // quiet outputs in reset and at its release
  reset_low: assert property (@(posedge clk_i) !rst_ni || $rose(rst_ni) |-> outs_low)
    else begin
      $error("fetch stage outputs active around reset");
      fail_cnt++;
    end

endmodule

bind if_stage_top if_stage_sva i_if_stage_sva (.*);

`default_nettype wire

// ==== bench/tb_if_stage.sv ====
// testbench of the instruction fetch stage
// clock, reset, instruction bus memory model
// directed tests for boot, back-pressure, trap targets, returns and fetch errors
`default_nettype none

module tb_if_stage import if_pkg::*; ();

  localparam addr_t       DmHaltAddr    = 32'h0000_0800;
  localparam addr_t       DmExcAddr     = 32'h0000_0808;
  localparam int unsigned NumIrq        = 64;
  localparam int          TimeoutCycles = 100;
  // memory data is the address with this key applied
  localparam instr_t      DataKey       = 32'h5a5a_0000;

  logic                      clk_i = 1'b0;
  logic                      rst_ni;
  addr_t                     boot_addr_i;
  logic                      req_i;
  logic                      instr_req_o;
  addr_t                     instr_addr_o;
  logic                      instr_gnt_i;
  logic                      instr_rvalid_i;
  instr_t                    instr_rdata_i;
  logic                      instr_err_i;
  logic                      pc_set_i;
  pc_sel_e                   pc_mux_i;
  exc_pc_sel_e               exc_pc_mux_i;
  irq_vec_t                  exc_cause_i;
  logic                      irq_shv_i;
  logic [$clog2(NumIrq)-1:0] clic_irq_id_i;
  addr_t                     branch_target_i;
  trap_csr_t                 csr_i;
  logic                      pmp_err_i;
  logic                      id_in_ready_i;
  logic                      instr_valid_clear_i;
  id_instr_t                 id_instr_o;
  logic                      instr_valid_id_o;
  logic                      instr_new_id_o;
  addr_t                     pc_if_o;
  logic                      minhv_o;
  logic                      csr_mtvec_init_o;
  logic                      csr_mtvt_init_o;
  logic                      pc_mismatch_alert_o;
  logic                      if_busy_o;
  integer                    seed = 32'hc80ad188;

  if_stage_top #(
    .DmHaltAddr      (DmHaltAddr),
    .DmExceptionAddr (DmExcAddr),
    .NumInterrupts   (NumIrq),
    .ClicShv         (1'b1),
    .ResetAll        (1'b0),
    .PcIncrCheck     (1'b1)
  ) i_if_stage_top (.*);

  always #2 clk_i = ~clk_i;

  ////////////////////////////////////////////////////////////
  // failure reporting and compare tasks
  ////////////////////////////////////////////////////////////

  task automatic report_failure(string what);
    $display("%s", what);
    $display("Simulation FAILED");
    $fatal(1, "stopping at the first failure");
  endtask

  task automatic check_bit(string name, logic act, logic exp);
    if (act !== exp) begin
      report_failure($sformatf("Error at %0t: %s expected %b got %b", $time, name, exp, act));
    end
  endtask

  task automatic check_addr(string name, addr_t act, addr_t exp);
    if (act !== exp) begin
      report_failure($sformatf("Error at %0t: %s expected %h got %h", $time, name, exp, act));
    end
  endtask

  task automatic check_instr(string name, instr_t act, instr_t exp);
    if (act !== exp) begin
      report_failure($sformatf("Error at %0t: %s expected %h got %h", $time, name, exp, act));
    end
  endtask

  task automatic check_id(string name, id_instr_t act, id_instr_t exp);
    if (act !== exp) begin
      report_failure($sformatf("Error at %0t: %s expected %h got %h", $time, name, exp, act));
    end
  endtask

  ////////////////////////////////////////////////////////////
  // instruction memory model
  ////////////////////////////////////////////////////////////

  // grant after 0 to 2 cycles and rvalid 1 to 3 cycles after the grant
  initial begin : bus_model
    int    gnt_wait;
    int    rv_wait;
    logic  gnt_drawn;
    logic  pending;
    addr_t granted_addr;
    gnt_wait       = 0;
    rv_wait        = 0;
    gnt_drawn      = 1'b0;
    pending        = 1'b0;
    granted_addr   = '0;
    instr_gnt_i    = 1'b0;
    instr_rvalid_i = 1'b0;
    instr_rdata_i  = '0;
    instr_err_i    = 1'b0;
    forever begin
      @(posedge clk_i);
      #1;
      // the grant of the last cycle was taken at this edge
      if (instr_gnt_i) begin
        pending = 1'b1;
        rv_wait = 1 + ($unsigned($random(seed)) % 3);
      end
      instr_gnt_i    = 1'b0;
      instr_rvalid_i = 1'b0;
      if (pending) begin
        rv_wait = rv_wait - 1;
        if (rv_wait == 0) begin
          pending        = 1'b0;
          instr_rvalid_i = 1'b1;
          instr_rdata_i  = granted_addr ^ DataKey;
          // error region 0xf000 to 0xffff
          instr_err_i    = (granted_addr >= 32'h0000_f000) && (granted_addr <= 32'h0000_ffff);
        end
      end else if (instr_req_o) begin
        if (!gnt_drawn) begin
          gnt_wait  = $unsigned($random(seed)) % 3;
          gnt_drawn = 1'b1;
        end
        if (gnt_wait == 0) begin
          instr_gnt_i  = 1'b1;
          granted_addr = instr_addr_o;
          gnt_drawn    = 1'b0;
        end else begin
          gnt_wait = gnt_wait - 1;
        end
      end
    end
  end

  // sequential fetches never trip the PC check
  always @(negedge clk_i) begin
    if (rst_ni && pc_mismatch_alert_o) begin
      report_failure("PC mismatch alert raised although the fetched PCs were sequential");
    end
  end

  ////////////////////////////////////////////////////////////
  // driver and monitor tasks
  ////////////////////////////////////////////////////////////

  // one cycle PC set with ID ready and no clear
  task automatic redirect(pc_sel_e sel, exc_pc_sel_e mode, logic shv, logic exp_minhv);
    @(posedge clk_i);
    #1;
    pc_set_i            = 1'b1;
    pc_mux_i            = sel;
    exc_pc_mux_i        = mode;
    irq_shv_i           = shv;
    id_in_ready_i       = 1'b1;
    instr_valid_clear_i = 1'b0;
    @(negedge clk_i);
    check_bit("minhv_o", minhv_o, exp_minhv);
    check_bit("csr_mtvec_init_o", csr_mtvec_init_o, sel == PC_BOOT);
    check_bit("csr_mtvt_init_o", csr_mtvt_init_o, sel == PC_BOOT);
    @(posedge clk_i);
    #1;
    pc_set_i  = 1'b0;
    irq_shv_i = 1'b0;
    // nothing is accepted in the redirect cycle
    check_bit("instr_new_id_o", instr_new_id_o, 1'b0);
  endtask

  task automatic wait_new_word(output id_instr_t word);
    int cycles;
    cycles = 0;
    do begin
      @(posedge clk_i);
      #1;
      cycles++;
      if (cycles > TimeoutCycles) begin
        report_failure("timeout while waiting for a new instruction in ID");
      end
    end while (!instr_new_id_o);
    word = id_instr_o;
  endtask

  task automatic expect_word(addr_t exp_pc, logic exp_err);
    id_instr_t word;
    id_instr_t exp_word;
    wait_new_word(word);
    exp_word = '{instr: exp_pc ^ DataKey, pc: exp_pc, fetch_err: exp_err};
    check_id("id_instr_o", word, exp_word);
    check_bit("instr_valid_id_o", instr_valid_id_o, 1'b1);
  endtask

  ////////////////////////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////////////////////////

  task automatic boot_sequence();
    boot_addr_i = 32'h0000_2345;
    redirect(PC_BOOT, EXC_PC_EXC, 1'b0, 1'b0);
    check_bit("if_busy_o", if_busy_o, 1'b1);
    // upper 24 bits of the boot address with low byte 0x80
    expect_word(32'h0000_2380, 1'b0);
  endtask

  task automatic sequential_fetch();
    addr_t exp_pc;
    addr_t last_pc_if;
    int    seen;
    int    cycles;
    branch_target_i = 32'h0000_1000;
    redirect(PC_JUMP, EXC_PC_EXC, 1'b0, 1'b0);
    exp_pc     = 32'h0000_1000;
    last_pc_if = '0;
    seen       = 0;
    cycles     = 0;
    while (seen < 24) begin
      @(posedge clk_i);
      #1;
      if (instr_new_id_o) begin
        // IF PC of the cycle in which the word was taken
        check_addr("pc_if_o", last_pc_if, exp_pc);
        check_addr("id_instr_o.pc", id_instr_o.pc, exp_pc);
        check_instr("id_instr_o.instr", id_instr_o.instr, exp_pc ^ DataKey);
        check_bit("id_instr_o.fetch_err", id_instr_o.fetch_err, 1'b0);
        exp_pc = exp_pc + 32'd4;
        seen++;
      end
      last_pc_if = pc_if_o;
      // ID stalls about one cycle in three
      id_in_ready_i = ($unsigned($random(seed)) % 3) != 0;
      cycles++;
      if (cycles > TimeoutCycles * 8) begin
        report_failure("timeout while fetching the sequential block");
      end
    end
    id_in_ready_i = 1'b1;
  endtask

  task automatic trap_targets();
    // mtvec 0x41e3, mtvt 0x6047, cause 13, CLIC id 37
    redirect(PC_EXC, EXC_PC_EXC, 1'b0, 1'b0);
    expect_word(32'h0000_4100, 1'b0);
    redirect(PC_EXC, EXC_PC_IRQ, 1'b0, 1'b0);
    expect_word(32'h0000_4134, 1'b0);
    redirect(PC_EXC, EXC_PC_DBD, 1'b0, 1'b0);
    expect_word(DmHaltAddr, 1'b0);
    redirect(PC_EXC, EXC_PC_DBG_EXC, 1'b0, 1'b0);
    expect_word(DmExcAddr, 1'b0);
    // CLIC without SHV uses mtvec aligned to 64 bytes
    redirect(PC_EXC, EXC_PC_IRQ_CLIC, 1'b0, 1'b0);
    expect_word(32'h0000_41c0, 1'b0);
    // table entry 0x6040 + 37 * 4
    redirect(PC_EXC, EXC_PC_IRQ_CLIC, 1'b1, 1'b1);
    expect_word(32'h0000_60d4, 1'b0);
  endtask

  task automatic returns_and_jumps();
    int cycles;
    // low two bits of the target are dropped
    branch_target_i = 32'h0000_3a02;
    redirect(PC_JUMP, EXC_PC_EXC, 1'b0, 1'b0);
    expect_word(32'h0000_3a00, 1'b0);
    redirect(PC_ERET, EXC_PC_EXC, 1'b0, 1'b0);
    expect_word(32'h0000_5004, 1'b0);
    redirect(PC_DRET, EXC_PC_EXC, 1'b0, 1'b0);
    expect_word(32'h0000_5808, 1'b0);
    // stall ID until a word sits in the fetch unit
    id_in_ready_i = 1'b0;
    cycles        = 0;
    do begin
      @(negedge clk_i);
      cycles++;
      if (cycles > TimeoutCycles) begin
        report_failure("timeout while waiting for a word to be held under back-pressure");
      end
    end while (!instr_rvalid_i);
    @(posedge clk_i);
    #1;
    instr_valid_clear_i = 1'b1;
    branch_target_i     = 32'h0000_7000;
    // held word is offered with the PC set and must be squashed
    redirect(PC_JUMP, EXC_PC_EXC, 1'b0, 1'b0);
    check_bit("instr_valid_id_o", instr_valid_id_o, 1'b0);
    expect_word(32'h0000_7000, 1'b0);
  endtask

  task automatic fetch_errors();
    // two words in the bus error region and the first word past it
    branch_target_i = 32'h0000_fff8;
    redirect(PC_JUMP, EXC_PC_EXC, 1'b0, 1'b0);
    expect_word(32'h0000_fff8, 1'b1);
    expect_word(32'h0000_fffc, 1'b1);
    expect_word(32'h0001_0000, 1'b0);
    // PMP error on a clean bus access
    branch_target_i = 32'h0000_3000;
    pmp_err_i       = 1'b1;
    redirect(PC_JUMP, EXC_PC_EXC, 1'b0, 1'b0);
    expect_word(32'h0000_3000, 1'b1);
    pmp_err_i           = 1'b0;
    id_in_ready_i       = 1'b0;
    instr_valid_clear_i = 1'b1;
    @(posedge clk_i);
    #1;
    instr_valid_clear_i = 1'b0;
    check_bit("instr_valid_id_o", instr_valid_id_o, 1'b0);
    id_in_ready_i = 1'b1;
  endtask

  ////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////

  initial begin : main
    rst_ni              = 1'b0;
    boot_addr_i         = '0;
    req_i               = 1'b1;
    pc_set_i            = 1'b0;
    pc_mux_i            = PC_BOOT;
    exc_pc_mux_i        = EXC_PC_EXC;
    exc_cause_i         = 5'd13;
    irq_shv_i           = 1'b0;
    clic_irq_id_i       = 6'd37;
    branch_target_i     = '0;
    csr_i               = '{mtvec: 32'h0000_41e3, mepc: 32'h0000_5004,
                            depc: 32'h0000_5808, mtvt: 32'h0000_6047};
    pmp_err_i           = 1'b0;
    id_in_ready_i       = 1'b1;
    instr_valid_clear_i = 1'b0;
    repeat (3) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;

    boot_sequence();
    sequential_fetch();
    trap_targets();
    returns_and_jumps();
    fetch_errors();

    if (i_if_stage_top.i_if_stage_sva.fail_cnt == 0) begin
      $display("Simulation PASSED");
      $finish;
    end else begin
      report_failure("concurrent assertions on the fetch stage failed");
    end
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
rtl/if_pkg.sv
rtl/exc_pc_gen.sv
rtl/pc_sel.sv
rtl/fetch_unit.sv
rtl/if_id_regs.sv
rtl/pc_incr_check.sv
rtl/if_stage_top.sv
bench/if_stage_sva.sv
bench/tb_if_stage.sv

// ==== Makefile ====
# Verilator build and run of the fetch stage testbench

VERILATOR ?= verilator
TOP       ?= tb_if_stage
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= Simulation PASSED

SOURCES := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
